// File: common/quant_cfg.svh
// ############################################################################
// Requantization stage sizes
// Lane count, data path widths and parameter field widths
// ############################################################################

`ifndef QUANT_CFG_SVH
`define QUANT_CFG_SVH

// Number of parallel lanes
`define NUM_ELEMENTS 8

// Data path widths
`define INPUT_WIDTH 20
`define OUTPUT_WIDTH 8

// Per-lane parameter fields
`define SCALE_BITS 16
`define SHIFT_BITS 4
`define OFFSET_BITS 8
`define SCALE_FRAC 8

`define LANE_ADDR_BITS 3

`endif

// File: common/quant_pkg.sv
// ############################################################################
// Requantization data path types
// Widths of the accumulator, parameter and output values
// ############################################################################

`include "quant_cfg.svh"

package quant_pkg;

    // Accumulator result from the array
    typedef logic signed [`INPUT_WIDTH-1:0] acc_t;

    // Per-lane parameters
    typedef logic signed [`SCALE_BITS-1:0] scale_t;
    typedef logic [`SHIFT_BITS-1:0] shift_t;
    typedef logic signed [`OFFSET_BITS-1:0] offset_t;

    // Read as signed or unsigned depending on the mode
    typedef logic [`OUTPUT_WIDTH-1:0] qout_t;

    // Host word, wide enough for the scale field
    typedef logic [`SCALE_BITS-1:0] param_word_t;

    typedef logic [3:0] out_bits_t;

endpackage

// File: common/ctrl_pkg.sv
// ############################################################################
// Parameter load control types
// Sequencer states and the lane address width
// ############################################################################

`include "quant_cfg.svh"

package ctrl_pkg;

    typedef logic [`LANE_ADDR_BITS-1:0] lane_addr_t;

    // Load order is scale, shift, offset
    typedef enum logic [2:0] {
        IDLE,
        LOAD_SCALE,
        LOAD_SHIFT,
        LOAD_OFFSET,
        READY
    } load_state_e;

endpackage

// File: common/param_wr_if.sv
// ############################################################################
// Parameter write bus
// Carries the field write enables, the lane address and the load word
// ############################################################################

`timescale 1ns/1ps

interface param_wr_if;

    // One-hot or idle, never two at once
    logic scale_we;
    logic shift_we;
    logic offset_we;

    // Driven by the lane counter
    ctrl_pkg::lane_addr_t addr;
    logic last;

    quant_pkg::param_word_t data;

    modport sequencer (
        output scale_we,
        output shift_we,
        output offset_we,
        output data,
        input  last
    );

    modport memory (
        input scale_we,
        input shift_we,
        input offset_we,
        input addr,
        input data
    );

endinterface

// File: output_scaler_set/output_scaler.sv
// ############################################################################
// Output scaler lane
// Two stages: multiply by scale, then shift, add offset and saturate
// ############################################################################

`timescale 1ns/1ps

`include "quant_cfg.svh"

module output_scaler (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 valid_i,
    input  quant_pkg::acc_t      wx_i,
    input  quant_pkg::scale_t    scale_i,
    input  quant_pkg::shift_t    shift_i,
    input  quant_pkg::offset_t   offset_i,
    input  logic                 cfg_unsigned_i,
    input  quant_pkg::out_bits_t cfg_output_bits_i,
    output logic                 valid_o,
    output quant_pkg::qout_t     y_o
);

    localparam int prod_w = `INPUT_WIDTH + `SCALE_BITS;
    // One extra bit so the offset add cannot wrap
    localparam int sum_w  = prod_w + 1;

    logic signed [prod_w-1:0] prod_q;
    logic                     valid_q;
    logic                     unsigned_q;
    quant_pkg::out_bits_t     bits_q;

    quant_pkg::out_bits_t     n_eff;
    logic signed [prod_w-1:0] shifted;
    logic signed [sum_w-1:0]  sum;
    logic [sum_w-1:0]         pow2;
    logic signed [sum_w-1:0]  hi;
    logic signed [sum_w-1:0]  lo;
    logic signed [sum_w-1:0]  clamped;

    // Valid bits of both stages
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid_q <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            valid_q <= valid_i;
            valid_o <= valid_q;
        end
    end

    // Stage 1 product and the mode travelling with it
    always_ff @(posedge clk) begin
        prod_q     <= wx_i * scale_i;
        unsigned_q <= cfg_unsigned_i;
        bits_q     <= cfg_output_bits_i;
    end

    always_comb begin
        // 0 or out of range selects the full width
        if (bits_q == '0 || bits_q > quant_pkg::out_bits_t'(`OUTPUT_WIDTH)) begin
            n_eff = quant_pkg::out_bits_t'(`OUTPUT_WIDTH);
        end else begin
            n_eff = bits_q;
        end

        // Arithmetic shift floors toward minus infinity
        shifted = prod_q >>> (`SCALE_FRAC + shift_i);
        sum     = shifted + offset_i;

        pow2 = sum_w'(1) << n_eff;
        if (unsigned_q) begin
            hi = $signed(pow2) - 1;
            lo = '0;
        end else begin
            hi = $signed(pow2 >> 1) - 1;
            lo = -$signed(pow2 >> 1);
        end

        if (sum > hi) begin
            clamped = hi;
        end else if (sum < lo) begin
            clamped = lo;
        end else begin
            clamped = sum;
        end
    end

    always_ff @(posedge clk) begin
        y_o <= quant_pkg::qout_t'(clamped[`OUTPUT_WIDTH-1:0]);
    end

endmodule

// File: output_scaler_set/output_scaler_set.sv
// ############################################################################
// Output scaler set
// Per-lane scale, shift and offset storage feeding one scaler per lane
// ############################################################################

`timescale 1ns/1ps

`include "quant_cfg.svh"

module output_scaler_set (
    input  logic                                        clk,
    input  logic                                        nrst,

    // Parameter writes from the load sequencer
    param_wr_if.memory                                  wr,

    input  logic                                        in_valid_i,
    input  quant_pkg::acc_t [`NUM_ELEMENTS-1:0]          wx_i,
    input  logic                                        cfg_unsigned_i,
    input  quant_pkg::out_bits_t                        cfg_output_bits_i,

    output logic                                        y_valid_o,
    output quant_pkg::qout_t [`NUM_ELEMENTS-1:0]         y_o
);

    quant_pkg::scale_t  scale_mem  [`NUM_ELEMENTS];
    quant_pkg::shift_t  shift_mem  [`NUM_ELEMENTS];
    quant_pkg::offset_t offset_mem [`NUM_ELEMENTS];

    logic [`NUM_ELEMENTS-1:0] lane_valid;

    // Parameters read as zero until the first load
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `NUM_ELEMENTS; i++) begin
                scale_mem[i]  <= '0;
                shift_mem[i]  <= '0;
                offset_mem[i] <= '0;
            end
        end else begin
            if (wr.scale_we) begin
                scale_mem[wr.addr] <= quant_pkg::scale_t'(wr.data);
            end
            // Shift and offset keep only the low bits of the word
            if (wr.shift_we) begin
                shift_mem[wr.addr] <= quant_pkg::shift_t'(wr.data[`SHIFT_BITS-1:0]);
            end
            if (wr.offset_we) begin
                offset_mem[wr.addr] <= quant_pkg::offset_t'(wr.data[`OFFSET_BITS-1:0]);
            end
        end
    end

    genvar g;
    generate
        for (g = 0; g < `NUM_ELEMENTS; g++) begin : g_lane
            output_scaler u_output_scaler (
                .clk               (clk),
                .nrst              (nrst),
                .valid_i           (in_valid_i),
                .wx_i              (wx_i[g]),
                .scale_i           (scale_mem[g]),
                .shift_i           (shift_mem[g]),
                .offset_i          (offset_mem[g]),
                .cfg_unsigned_i    (cfg_unsigned_i),
                .cfg_output_bits_i (cfg_output_bits_i),
                .valid_o           (lane_valid[g]),
                .y_o               (y_o[g])
            );
        end
    endgenerate

    // All lanes run in lockstep
    assign y_valid_o = lane_valid[0];

endmodule

// File: design/param_load_ctrl.sv
// ############################################################################
// Parameter load sequencer
// Steers host words to the scale, shift and offset memories in turn
// ############################################################################

`timescale 1ns/1ps

`include "quant_cfg.svh"

module param_load_ctrl (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   load_start_i,
    input  logic                   param_valid_i,
    input  quant_pkg::param_word_t param_data_i,
    output logic                   ready_o,
    param_wr_if.sequencer          wr
);

    ctrl_pkg::load_state_e state_q;
    ctrl_pkg::load_state_e state_d;

    logic word_ok;
    logic phase_done;

    // A start pulse wins over a word in the same cycle
    assign word_ok = param_valid_i && !load_start_i;

    assign wr.scale_we  = word_ok && (state_q == ctrl_pkg::LOAD_SCALE);
    assign wr.shift_we  = word_ok && (state_q == ctrl_pkg::LOAD_SHIFT);
    assign wr.offset_we = word_ok && (state_q == ctrl_pkg::LOAD_OFFSET);
    assign wr.data      = param_data_i;

    // Word written at the final lane closes the phase
    assign phase_done = wr.last && (wr.scale_we || wr.shift_we || wr.offset_we);

    always_comb begin
        state_d = state_q;
        if (load_start_i) begin
            state_d = ctrl_pkg::LOAD_SCALE;
        end else if (phase_done) begin
            case (state_q)
                ctrl_pkg::LOAD_SCALE:  state_d = ctrl_pkg::LOAD_SHIFT;
                ctrl_pkg::LOAD_SHIFT:  state_d = ctrl_pkg::LOAD_OFFSET;
                ctrl_pkg::LOAD_OFFSET: state_d = ctrl_pkg::READY;
                default:               state_d = state_q;
            endcase
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= ctrl_pkg::IDLE;
            ready_o <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_o <= (state_d == ctrl_pkg::READY);
        end
    end

endmodule

// File: design/lane_counter.sv
// ############################################################################
// Lane address counter
// Walks the lanes during a load phase and flags the final lane
// ############################################################################

`timescale 1ns/1ps

`include "quant_cfg.svh"

module lane_counter (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 clear_i,
    input  logic                 step_i,
    output ctrl_pkg::lane_addr_t addr_o,
    output logic                 last_o
);

    localparam ctrl_pkg::lane_addr_t last_lane = ctrl_pkg::lane_addr_t'(`NUM_ELEMENTS - 1);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            addr_o <= '0;
        end else if (clear_i) begin
            addr_o <= '0;
        end else if (step_i) begin
            // Wrap back for the next field
            if (addr_o == last_lane) begin
                addr_o <= '0;
            end else begin
                addr_o <= addr_o + 1'b1;
            end
        end
    end

    assign last_o = (addr_o == last_lane);

endmodule

// File: design/requant_top.sv
// ############################################################################
// Requantization stage top level
// Parameter load path plus the per-lane output scalers
// ############################################################################

`timescale 1ns/1ps

`include "quant_cfg.svh"

module requant_top (
    input  logic                                 clk,
    input  logic                                 nrst,

    // Parameter load port
    input  logic                                 load_start_i,
    input  logic                                 param_valid_i,
    input  quant_pkg::param_word_t               param_data_i,
    output logic                                 ready_o,

    // Data path
    input  logic                                 wx_valid_i,
    input  quant_pkg::acc_t [`NUM_ELEMENTS-1:0]   wx_i,
    input  logic                                 cfg_unsigned_i,
    input  quant_pkg::out_bits_t                 cfg_output_bits_i,
    output logic                                 y_valid_o,
    output quant_pkg::qout_t [`NUM_ELEMENTS-1:0]  y_o
);

    param_wr_if wr_bus ();

    logic lane_step;
    logic in_valid;

    assign lane_step = wr_bus.scale_we | wr_bus.shift_we | wr_bus.offset_we;

    // Vectors are dropped until the parameters are loaded
    assign in_valid = wx_valid_i & ready_o;

    param_load_ctrl u_param_load_ctrl (
        .clk           (clk),
        .nrst          (nrst),
        .load_start_i  (load_start_i),
        .param_valid_i (param_valid_i),
        .param_data_i  (param_data_i),
        .ready_o       (ready_o),
        .wr            (wr_bus.sequencer)
    );

    lane_counter u_lane_counter (
        .clk     (clk),
        .nrst    (nrst),
        .clear_i (load_start_i),
        .step_i  (lane_step),
        .addr_o  (wr_bus.addr),
        .last_o  (wr_bus.last)
    );

    output_scaler_set u_output_scaler_set (
        .clk               (clk),
        .nrst              (nrst),
        .wr                (wr_bus.memory),
        .in_valid_i        (in_valid),
        .wx_i              (wx_i),
        .cfg_unsigned_i    (cfg_unsigned_i),
        .cfg_output_bits_i (cfg_output_bits_i),
        .y_valid_o         (y_valid_o),
        .y_o               (y_o)
    );

endmodule

// File: testbench/tb_requant_top.sv
// ############################################################################
// Requantization stage testbench
// Loads parameters, streams vectors and checks the outputs against a model
// ############################################################################

`timescale 1ns/1ps

`include "quant_cfg.svh"

module tb_requant_top;

    // Three loads and about 100 vectors fit well inside this
    localparam int max_cycles = 2000;
    localparam int load_words = 3 * `NUM_ELEMENTS;

    logic                                  clk;
    logic                                  nrst;
    logic                                  load_start_i;
    logic                                  param_valid_i;
    quant_pkg::param_word_t                param_data_i;
    logic                                  ready_o;
    logic                                  wx_valid_i;
    quant_pkg::acc_t [`NUM_ELEMENTS-1:0]   wx_i;
    logic                                  cfg_unsigned_i;
    quant_pkg::out_bits_t                  cfg_output_bits_i;
    logic                                  y_valid_o;
    quant_pkg::qout_t [`NUM_ELEMENTS-1:0]  y_o;

    // Words as the testbench loaded them, one set per field
    quant_pkg::param_word_t scale_w  [`NUM_ELEMENTS];
    quant_pkg::param_word_t shift_w  [`NUM_ELEMENTS];
    quant_pkg::param_word_t offset_w [`NUM_ELEMENTS];

    // Expected vectors with the cycle they were issued in
    quant_pkg::qout_t [`NUM_ELEMENTS-1:0] exp_q [$];
    int                                   tag_q [$];
    quant_pkg::qout_t [`NUM_ELEMENTS-1:0] head_y;
    int                                   head_tag;
    logic                                 head_valid;

    int cycle;
    int errors;
    int checked;
    int words_sent;

    requant_top u_requant_top (
        .clk               (clk),
        .nrst              (nrst),
        .load_start_i      (load_start_i),
        .param_valid_i     (param_valid_i),
        .param_data_i      (param_data_i),
        .ready_o           (ready_o),
        .wx_valid_i        (wx_valid_i),
        .wx_i              (wx_i),
        .cfg_unsigned_i    (cfg_unsigned_i),
        .cfg_output_bits_i (cfg_output_bits_i),
        .y_valid_o         (y_valid_o),
        .y_o               (y_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("tests failed");
            $finish;
        end
    end

    // Output stable here, so the next edge compares against this head
    always @(negedge clk) begin
        if (y_valid_o) begin
            if (exp_q.size() > 0) begin
                head_y     = exp_q.pop_front();
                head_tag   = tag_q.pop_front();
                head_valid = 1'b1;
                checked++;
            end else begin
                head_valid = 1'b0;
            end
        end
    end

    // y = clamp(floor(wx * scale / 2^(frac + shift)) + offset)
    function automatic quant_pkg::qout_t model_lane(input int lane, input quant_pkg::acc_t wx,
                                                    input logic uns,
                                                    input quant_pkg::out_bits_t bits);
        longint prod;
        longint div;
        longint v;
        longint hi;
        longint lo;
        int     n;
        prod = longint'(wx) * longint'($signed(scale_w[lane]));
        div  = longint'(1) << (`SCALE_FRAC + shift_w[lane][`SHIFT_BITS-1:0]);
        v    = prod / div;
        if ((prod % div) != 0 && prod < 0) begin
            v = v - 1;
        end
        v = v + longint'($signed(offset_w[lane][`OFFSET_BITS-1:0]));
        n = (bits == 0 || bits > `OUTPUT_WIDTH) ? `OUTPUT_WIDTH : int'(bits);
        if (uns) begin
            lo = 0;
            hi = (longint'(1) << n) - 1;
        end else begin
            lo = -(longint'(1) << (n - 1));
            hi = (longint'(1) << (n - 1)) - 1;
        end
        if (v > hi) v = hi;
        if (v < lo) v = lo;
        return quant_pkg::qout_t'(v[`OUTPUT_WIDTH-1:0]);
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            wx_valid_i    = 1'b0;
            param_valid_i = 1'b0;
        end
    endtask

    // Leaves wx_valid_i high so calls can run back to back
    task automatic send_vector(input logic uns, input quant_pkg::out_bits_t bits,
                               input bit accepted);
        quant_pkg::qout_t [`NUM_ELEMENTS-1:0] exp_y;
        @(posedge clk);
        #1;
        for (int i = 0; i < `NUM_ELEMENTS; i++) begin
            wx_i[i]  = quant_pkg::acc_t'($urandom) >>> $urandom_range(0, 15);
            exp_y[i] = model_lane(i, wx_i[i], uns, bits);
        end
        wx_valid_i        = 1'b1;
        cfg_unsigned_i    = uns;
        cfg_output_bits_i = bits;
        if (accepted) begin
            exp_q.push_back(exp_y);
            tag_q.push_back(cycle);
        end
    endtask

    task automatic start_load();
        @(posedge clk);
        #1;
        load_start_i  = 1'b1;
        wx_valid_i    = 1'b0;
        param_valid_i = 1'b0;
        words_sent    = 0;
        @(posedge clk);
        #1;
        load_start_i = 1'b0;
    endtask

    // Scale words first, then shift, then offset, with random gaps
    task automatic write_words();
        for (int k = 0; k < load_words; k++) begin
            idle($urandom_range(0, 3));
            @(posedge clk);
            #1;
            param_valid_i = 1'b1;
            if (k < `NUM_ELEMENTS) param_data_i = scale_w[k];
            else if (k < 2 * `NUM_ELEMENTS) param_data_i = shift_w[k - `NUM_ELEMENTS];
            else param_data_i = offset_w[k - 2 * `NUM_ELEMENTS];
            words_sent++;
        end
        idle(1);
        while (!ready_o) @(posedge clk);
    endtask

    task automatic pick_random_params();
        for (int i = 0; i < `NUM_ELEMENTS; i++) begin
            scale_w[i]  = quant_pkg::param_word_t'($urandom);
            shift_w[i]  = quant_pkg::param_word_t'($urandom);
            offset_w[i] = quant_pkg::param_word_t'($urandom);
        end
    endtask

    // Unit gain of either sign with extreme offsets pushes into both limits
    task automatic pick_clamp_params();
        for (int i = 0; i < `NUM_ELEMENTS; i++) begin
            scale_w[i]  = (i % 2 == 0) ? 16'h0100 : 16'hff00;
            shift_w[i]  = 16'hfff0;
            offset_w[i] = (i < `NUM_ELEMENTS / 2) ? 16'h0080 : 16'h007f;
        end
    endtask

    assert property (@(posedge clk) disable iff (!nrst)
        y_valid_o == $past(wx_valid_i && ready_o, 2))
    else begin
        errors++;
        $display("FAIL %0t: y_valid_o not 2 cycles after an accepted vector", $time);
    end

    assert property (@(posedge clk) disable iff (!nrst)
        $past(wx_valid_i && !ready_o, 2) |-> !y_valid_o)
    else begin
        errors++;
        $display("FAIL %0t: vector given while not ready produced an output", $time);
    end

    assert property (@(posedge clk) disable iff (!nrst)
        y_valid_o |-> head_valid && (y_o == head_y))
    else begin
        errors++;
        $display("FAIL %0t: y_o %h, expected %h", $time, y_o, head_y);
    end

    assert property (@(posedge clk) disable iff (!nrst)
        y_valid_o |-> (cycle == head_tag + 2))
    else begin
        errors++;
        $display("FAIL %0t: output issued in cycle %0d seen in cycle %0d", $time,
                 head_tag, cycle);
    end

    assert property (@(posedge clk) disable iff (!nrst)
        $rose(ready_o) |-> (words_sent == load_words))
    else begin
        errors++;
        $display("FAIL %0t: ready_o rose after %0d words", $time, words_sent);
    end

    assert property (@(posedge clk) disable iff (!nrst)
        param_valid_i && (words_sent == load_words) |=> ready_o)
    else begin
        errors++;
        $display("FAIL %0t: ready_o low on the edge after the last word", $time);
    end

    assert property (@(posedge clk) disable iff (!nrst)
        load_start_i |=> !ready_o)
    else begin
        errors++;
        $display("FAIL %0t: ready_o still high after load_start_i", $time);
    end

    initial begin
        nrst              = 1'b0;
        load_start_i      = 1'b0;
        param_valid_i     = 1'b0;
        param_data_i      = '0;
        wx_valid_i        = 1'b0;
        wx_i              = '0;
        cfg_unsigned_i    = 1'b0;
        cfg_output_bits_i = '0;
        head_y            = '0;
        head_tag          = 0;
        head_valid        = 1'b0;
        cycle             = 0;
        errors            = 0;
        checked           = 0;
        words_sent        = 0;
        void'($urandom(7249));
        repeat (3) @(posedge clk);
        #1;
        nrst = 1'b1;

        // Nothing loaded yet, so these are dropped
        repeat (4) send_vector(1'b0, 4'd8, 1'b0);
        idle(3);

        pick_random_params();
        start_load();
        write_words();
        repeat (20) begin
            send_vector(1'b0, 4'd8, 1'b1);
            idle($urandom_range(1, 2));
        end

        pick_clamp_params();
        start_load();
        write_words();
        for (int i = 0; i < 27; i++) begin
            send_vector(1'b1, quant_pkg::out_bits_t'(i % 9), 1'b1);
            idle($urandom_range(0, 1));
        end
        for (int i = 0; i < 30; i++) begin
            send_vector(1'b0, quant_pkg::out_bits_t'(i % 10), 1'b1);
        end

        // Burst runs straight into a reload, then vectors while loading
        pick_random_params();
        start_load();
        repeat (3) send_vector(1'b0, 4'd8, 1'b0);
        write_words();
        repeat (16) send_vector(1'b0, 4'd8, 1'b1);
        idle(1);

        while (exp_q.size() > 0) @(posedge clk);
        repeat (3) @(posedge clk);
        $display("Summary: %0d vectors checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+common
common/quant_pkg.sv
common/ctrl_pkg.sv
common/param_wr_if.sv
output_scaler_set/output_scaler.sv
output_scaler_set/output_scaler_set.sv
design/param_load_ctrl.sv
design/lane_counter.sv
design/requant_top.sv
testbench/tb_requant_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the requantization testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_requant_top \
    -f files.f \
    -o sim_requant

./obj_dir/sim_requant > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi

exit 0
